//--- common/zx_bus_pkg.sv
`default_nettype none

package zx_bus_pkg;

	// ====================
	// Z80 bus
	// ====================

	localparam int CPU_ADDR_W = 16;   // A15..A0
	localparam int CPU_DATA_W = 8;

	// ====================
	// Memory modes
	// ====================

	// Code width matches the machine config selector
	localparam int MODE_W = 3;

	localparam logic [MODE_W-1:0] MODE_STD128 = 3'd0;  // 128K and +2
	localparam logic [MODE_W-1:0] MODE_P1024  = 3'd1;  // Pentagon 1024K
	localparam logic [MODE_W-1:0] MODE_PF1024 = 3'd2;  // Profi 1024K
	localparam logic [MODE_W-1:0] MODE_ZX48   = 3'd3;  // Paging locked out
	localparam logic [MODE_W-1:0] MODE_PLUS3  = 3'd4;  // +2A and +3

	// ====================
	// Paging ports
	// ====================

	// 7FFD, 1FFD and EFF7 are partially decoded from single address lines.
	// The Profi port is the only one that needs a full compare
	localparam logic [CPU_ADDR_W-1:0] PORT_DFFD = 16'hDFFD;

endpackage

`default_nettype wire

//--- common/zx_mem_pkg.sv
`default_nettype none

package zx_mem_pkg;

	// ====================
	// SDRAM address map
	// ====================

	localparam int RAM_ADDR_W = 24;                       // Byte address
	localparam int PAGE_OFS_W = 14;                       // Offset in a 16K page
	localparam int RAM_PAGE_W = RAM_ADDR_W - PAGE_OFS_W;  // 16K page number
	localparam int BANK_W     = 6;                        // 64 RAM pages, 1M
	localparam int ROM_PAGE_W = 4;

	// ROM images sit at 2M, sixteen pages of 16K
	localparam logic [RAM_PAGE_W-ROM_PAGE_W-1:0] ROM_BASE_TAG = 6'b00_1000;

	// ====================
	// Paging registers
	// ====================

	// 7FFD, same byte read two ways.
	// Pentagon 1024 reuses the upper bits as extra bank bits
	typedef union packed {
		struct packed {
			logic [1:0] unused;
			logic       lock;       // Freezes paging until reset
			logic       rom_sel;    // Low ROM select
			logic       screen;     // Shadow screen in bank 7
			logic [2:0] bank;       // Bank in slot 3
		} std_map;
		struct packed {
			logic [1:0] bank_hi;    // Pentagon bank bits 4:3
			logic       lock_bank;  // Bank bit 5, or lock with EFF7 bit 2
			logic [4:0] low;
		} ext_map;
	} page_7ffd_u;

	// 1FFD on the +2A/+3.
	// Special bit 0 switches all four slots to RAM
	typedef union packed {
		struct packed {
			logic [3:0] unused;
			logic       motor;      // Disk motor
			logic       rom_hi;     // High ROM select
			logic       unused_1;
			logic       special;    // Zero in this view
		} norm_map;
		struct packed {
			logic [3:0] unused;
			logic       motor;
			// 0: 0 1 2 3
			// 1: 4 5 6 7
			// 2: 4 5 6 3
			// 3: 4 7 6 3
			logic [1:0] cfg;
			logic       special;
		} spc_map;
	} page_1ffd_u;

endpackage

`default_nettype wire

//--- design/paging/addr_map.sv
`timescale 1ns/100ps
`default_nettype none

module addr_map (
	input  wire  [zx_bus_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  wire                               mreq_n,
	input  wire                               rd_n,
	input  wire                               wr_n,
	input  wire  [zx_bus_pkg::MODE_W-1:0]     mode,
	input  wire  zx_mem_pkg::page_7ffd_u      reg_7ffd,
	input  wire  zx_mem_pkg::page_1ffd_u      reg_1ffd,
	input  wire  [2:0]                        page_128k,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic                              ram_rd,
	output logic                              ram_we,
	output logic [zx_mem_pkg::ROM_PAGE_W-1:0] rom_page,
	output logic                              screen_page,
	output logic [zx_mem_pkg::BANK_W-1:0]     ram_ext_bank
);

	logic                              is_plus3;
	logic                              is_zx48;
	logic                              special;    // +3 all-RAM mode
	logic [1:0]                        slot;       // 16K slot of the CPU map
	logic [11:0]                       sp_banks;   // Slot 3 down to slot 0
	logic [2:0]                        sp_bank;
	logic [zx_mem_pkg::RAM_PAGE_W-1:0] ram_page;

	assign is_plus3 = (mode == zx_bus_pkg::MODE_PLUS3);
	assign is_zx48  = (mode == zx_bus_pkg::MODE_ZX48);
	assign special  = reg_1ffd.spc_map.special;
	assign slot     = cpu_addr[15:14];

	assign ram_ext_bank = {page_128k, reg_7ffd.std_map.bank};
	assign screen_page  = reg_7ffd.std_map.screen;

	// ====================
	// ROM select
	// ====================

	always_comb begin
		if (is_plus3)
			rom_page = {2'b01, reg_1ffd.norm_map.rom_hi, reg_7ffd.std_map.rom_sel};
		else if (is_zx48)
			rom_page = 4'b1101;   // 48K BASIC image
		else
			rom_page = {3'b001, reg_7ffd.std_map.rom_sel};
	end

	// ====================
	// Page select
	// ====================

	// Fixed +3 special layouts
	always_comb begin
		case (reg_1ffd.spc_map.cfg)
			2'd0:    sp_banks = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    sp_banks = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    sp_banks = {3'd3, 3'd6, 3'd5, 3'd4};
			default: sp_banks = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end

	assign sp_bank = sp_banks[3*slot +: 3];

	always_comb begin
		ram_page = '0;
		if (special) begin
			ram_page[2:0] = sp_bank;
		end else begin
			case (slot)
				2'd0:    ram_page = {zx_mem_pkg::ROM_BASE_TAG, rom_page};
				2'd1:    ram_page[2:0] = 3'd5;
				2'd2:    ram_page[2:0] = 3'd2;
				default: ram_page[zx_mem_pkg::BANK_W-1:0] = ram_ext_bank;
			endcase
		end
	end

	assign ram_addr = {ram_page, cpu_addr[zx_mem_pkg::PAGE_OFS_W-1:0]};

	// ROM space is read only, unless special mode put RAM there
	assign ram_rd = ~mreq_n & ~rd_n;
	assign ram_we = ~mreq_n & ~wr_n & ((|slot) | special);

endmodule

`default_nettype wire

//--- design/paging/page_regs.sv
`timescale 1ns/100ps
`default_nettype none

module page_regs (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire  [zx_bus_pkg::MODE_W-1:0]     memory_mode,
	input  wire                               wr_7ffd,
	input  wire                               wr_1ffd,
	input  wire                               wr_dffd,
	input  wire                               wr_eff7,
	input  wire  [zx_bus_pkg::CPU_DATA_W-1:0] wr_data,
	output logic [zx_bus_pkg::MODE_W-1:0]     mode,
	output zx_mem_pkg::page_7ffd_u            reg_7ffd,
	output zx_mem_pkg::page_1ffd_u            reg_1ffd,
	output logic [zx_bus_pkg::CPU_DATA_W-1:0] reg_eff7,
	output logic [2:0]                        page_128k,   // Bank bits 5:3
	output logic                              paging_locked
);

	logic is_zx48;
	logic is_p1024;
	logic p1024_compat;   // EFF7 bit 2, Pentagon 128 behaviour

	assign is_zx48      = (mode == zx_bus_pkg::MODE_ZX48);
	assign is_p1024     = (mode == zx_bus_pkg::MODE_P1024);
	assign p1024_compat = reg_eff7[2];

	// ====================
	// Lock
	// ====================

	// In Pentagon 1024 bit 5 is a bank bit,
	// and only turns back into the lock in compatible mode
	assign paging_locked = is_zx48
		| (~is_p1024 & reg_7ffd.std_map.lock)
		| (is_p1024 & p1024_compat & reg_7ffd.ext_map.lock_bank);

	// ====================
	// Registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode      <= memory_mode;   // Follows the selector while in reset
			reg_7ffd  <= '0;
			reg_1ffd  <= '0;
			reg_eff7  <= '0;
			page_128k <= '0;
		end else begin
			if (wr_7ffd && !paging_locked) begin
				reg_7ffd <= wr_data;
				// Pentagon order is bit 5, then 7:6
				if (is_p1024 && !p1024_compat)
					page_128k <= {wr_data[5], wr_data[7:6]};
			end

			if (wr_1ffd && !paging_locked)
				reg_1ffd <= wr_data;

			// Profi extension ignores the 7FFD lock
			if (wr_dffd)
				page_128k <= wr_data[2:0];

			if (wr_eff7)
				reg_eff7 <= wr_data;   // Only bit 2 matters for paging
		end
	end

endmodule

`default_nettype wire

//--- design/paging/port_decode.sv
`timescale 1ns/100ps
`default_nettype none

module port_decode (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire  [zx_bus_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  wire  [zx_bus_pkg::CPU_DATA_W-1:0] cpu_dout,
	input  wire                               iorq_n,
	input  wire                               wr_n,
	input  wire                               m1_n,
	input  wire  [zx_bus_pkg::MODE_W-1:0]     mode,
	output logic                              wr_7ffd,
	output logic                              wr_1ffd,
	output logic                              wr_dffd,
	output logic                              wr_eff7,
	output logic [zx_bus_pkg::CPU_DATA_W-1:0] wr_data
);

	logic                              io_wr;     // Bus level, M1 excludes INTA
	logic                              io_wr_q;
	logic                              io_wr_qq;
	logic                              wr_rise;
	logic [zx_bus_pkg::CPU_ADDR_W-1:0] addr_q;
	logic [zx_bus_pkg::CPU_DATA_W-1:0] data_q;
	logic                              is_plus3;
	logic                              is_p1024;
	logic                              is_pf1024;
	logic                              hit_7ffd;
	logic                              hit_1ffd;
	logic                              hit_dffd;
	logic                              hit_eff7;

	assign io_wr   = ~iorq_n & ~wr_n & m1_n;
	assign wr_rise = io_wr_q & ~io_wr_qq;   // Long writes count once

	assign is_plus3  = (mode == zx_bus_pkg::MODE_PLUS3);
	assign is_p1024  = (mode == zx_bus_pkg::MODE_P1024);
	assign is_pf1024 = (mode == zx_bus_pkg::MODE_PF1024);

	// ====================
	// Port decode
	// ====================

	// The +3 decodes A14 as well, so 1FFD does not alias onto 7FFD
	assign hit_7ffd = ~addr_q[15] & ~addr_q[1] & (addr_q[14] | ~is_plus3);
	assign hit_1ffd = is_plus3 & ~addr_q[15] & ~addr_q[14] & ~addr_q[13] & addr_q[12]
		& ~addr_q[1];
	assign hit_dffd = is_pf1024 & (addr_q == zx_bus_pkg::PORT_DFFD);
	assign hit_eff7 = is_p1024 & addr_q[15] & addr_q[14] & addr_q[13] & ~addr_q[12]
		& ~addr_q[3];

	// Address and data captured with the level
	always_ff @(posedge clk_sys) begin
		addr_q <= cpu_addr;
		data_q <= cpu_dout;
		if (wr_rise) wr_data <= data_q;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			io_wr_qq <= 1'b0;
			wr_7ffd  <= 1'b0;
			wr_1ffd  <= 1'b0;
			wr_dffd  <= 1'b0;
			wr_eff7  <= 1'b0;
		end else begin
			io_wr_q  <= io_wr;
			io_wr_qq <= io_wr_q;
			wr_7ffd  <= wr_rise & hit_7ffd;   // One-cycle strobes
			wr_1ffd  <= wr_rise & hit_1ffd;
			wr_dffd  <= wr_rise & hit_dffd;
			wr_eff7  <= wr_rise & hit_eff7;
		end
	end

endmodule

`default_nettype wire

//--- design/zx_paging.sv
`timescale 1ns/100ps
`default_nettype none

module zx_paging (
	input  wire                               clk_sys,
	input  wire                               reset,
	input  wire  [zx_bus_pkg::MODE_W-1:0]     memory_mode,
	input  wire  [zx_bus_pkg::CPU_ADDR_W-1:0] cpu_addr,
	input  wire  [zx_bus_pkg::CPU_DATA_W-1:0] cpu_dout,
	input  wire                               iorq_n,
	input  wire                               mreq_n,
	input  wire                               rd_n,
	input  wire                               wr_n,
	input  wire                               m1_n,
	output logic [zx_mem_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic                              ram_rd,
	output logic                              ram_we,
	output logic [zx_mem_pkg::ROM_PAGE_W-1:0] rom_page,
	output logic                              screen_page,
	output logic [zx_mem_pkg::BANK_W-1:0]     ram_ext_bank
);

	logic                              wr_7ffd;
	logic                              wr_1ffd;
	logic                              wr_dffd;
	logic                              wr_eff7;
	logic [zx_bus_pkg::CPU_DATA_W-1:0] wr_data;
	logic [zx_bus_pkg::MODE_W-1:0]     mode;
	zx_mem_pkg::page_7ffd_u            reg_7ffd;
	zx_mem_pkg::page_1ffd_u            reg_1ffd;
	logic [2:0]                        page_128k;

	// ====================
	// Port writes
	// ====================

	port_decode u_port_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.iorq_n   (iorq_n),
		.wr_n     (wr_n),
		.m1_n     (m1_n),
		.mode     (mode),
		.wr_7ffd  (wr_7ffd),
		.wr_1ffd  (wr_1ffd),
		.wr_dffd  (wr_dffd),
		.wr_eff7  (wr_eff7),
		.wr_data  (wr_data)
	);

	// EFF7 and the lock only steer the register updates
	page_regs u_page_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.memory_mode   (memory_mode),
		.wr_7ffd       (wr_7ffd),
		.wr_1ffd       (wr_1ffd),
		.wr_dffd       (wr_dffd),
		.wr_eff7       (wr_eff7),
		.wr_data       (wr_data),
		.mode          (mode),
		.reg_7ffd      (reg_7ffd),
		.reg_1ffd      (reg_1ffd),
		.reg_eff7      (),
		.page_128k     (page_128k),
		.paging_locked ()
	);

	// ====================
	// Memory map
	// ====================

	addr_map u_addr_map (
		.cpu_addr     (cpu_addr),
		.mreq_n       (mreq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.mode         (mode),
		.reg_7ffd     (reg_7ffd),
		.reg_1ffd     (reg_1ffd),
		.page_128k    (page_128k),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.rom_page     (rom_page),
		.screen_page  (screen_page),
		.ram_ext_bank (ram_ext_bank)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the paging testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
	-f zx_paging.f --top-module tb_zx_paging -o sim_zx_paging
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_zx_paging > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- verif/paging_model.svh
`ifndef PAGING_MODEL_SVH
`define PAGING_MODEL_SVH

// ====================
// Model state
// ====================

logic [zx_bus_pkg::MODE_W-1:0] m_mode;
logic [7:0]                    m_7ffd;
logic [7:0]                    m_1ffd;
logic [7:0]                    m_eff7;
logic [2:0]                    m_bank_hi;   // Extension bits above the 128K bank

task automatic model_reset(input logic [zx_bus_pkg::MODE_W-1:0] mode);
	m_mode    = mode;
	m_7ffd    = 8'h00;
	m_1ffd    = 8'h00;
	m_eff7    = 8'h00;
	m_bank_hi = 3'b000;
endtask

function automatic logic model_locked();
	if (m_mode == zx_bus_pkg::MODE_ZX48)
		return 1'b1;
	if (m_mode == zx_bus_pkg::MODE_P1024)
		return m_eff7[2] & m_7ffd[5];   // Bank bit unless EFF7 bit 2 set
	return m_7ffd[5];
endfunction

function automatic logic model_special();
	return (m_mode == zx_bus_pkg::MODE_PLUS3) && m_1ffd[0];
endfunction

// Port hits follow the partial decode of each machine
task automatic model_io_write(input logic [15:0] a, input logic [7:0] d);
	logic locked;
	logic plus3;
	locked = model_locked();
	plus3  = (m_mode == zx_bus_pkg::MODE_PLUS3);
	if (!a[15] && !a[1] && (a[14] || !plus3) && !locked) begin
		m_7ffd = d;
		if (m_mode == zx_bus_pkg::MODE_P1024 && !m_eff7[2])
			m_bank_hi = {d[5], d[7:6]};
	end
	if (plus3 && a[15:12] == 4'b0001 && !a[1] && !locked)
		m_1ffd = d;
	if (m_mode == zx_bus_pkg::MODE_PF1024 && a == 16'hDFFD)
		m_bank_hi = d[2:0];   // Profi ignores the lock
	if (m_mode == zx_bus_pkg::MODE_P1024 && a[15:12] == 4'b1110 && !a[3])
		m_eff7 = d;
endtask

// ====================
// Expected outputs
// ====================

function automatic logic [zx_mem_pkg::ROM_PAGE_W-1:0] model_rom_page();
	if (m_mode == zx_bus_pkg::MODE_PLUS3)
		return {2'b01, m_1ffd[2], m_7ffd[4]};
	if (m_mode == zx_bus_pkg::MODE_ZX48)
		return 4'd13;
	return {3'b001, m_7ffd[4]};
endfunction

function automatic logic [zx_mem_pkg::BANK_W-1:0] model_ext_bank();
	return {m_bank_hi, m_7ffd[2:0]};
endfunction

// All-RAM layouts 0123, 4567, 4563, 4763
function automatic logic [2:0] special_bank(input logic [1:0] slot);
	case (m_1ffd[2:1])
		2'd0:    return {1'b0, slot};
		2'd1:    return {1'b1, slot};
		2'd2:    return (slot == 2'd3) ? 3'd3 : {1'b1, slot};
		default: begin
			case (slot)
				2'd0:    return 3'd4;
				2'd1:    return 3'd7;
				2'd2:    return 3'd6;
				default: return 3'd3;
			endcase
		end
	endcase
endfunction

function automatic logic [zx_mem_pkg::RAM_ADDR_W-1:0] model_ram_addr(input logic [15:0] a);
	logic [5:0]                        bank;
	logic [zx_mem_pkg::RAM_ADDR_W-1:0] addr;
	if (model_special())
		bank = {3'b000, special_bank(a[15:14])};
	else if (a[15:14] == 2'd0)
		return {zx_mem_pkg::ROM_BASE_TAG, model_rom_page(), a[13:0]};
	else if (a[15:14] == 2'd1)
		bank = 6'd5;
	else if (a[15:14] == 2'd2)
		bank = 6'd2;
	else
		bank = model_ext_bank();
	addr       = '0;
	addr[19:0] = {bank, a[13:0]};   // RAM pages from 0
	return addr;
endfunction

`endif

//--- verif/tb_zx_paging.sv
`timescale 1ns/100ps
`default_nettype none

module tb_zx_paging;

	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DLY    = 2;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_PASSES   = 2;
	localparam int NUM_TESTS    = NUM_PASSES * 5;
	localparam int OPS_PER_TEST = 40;
	// Reset and first sweep, then a write with its sweep counts five
	localparam int NUM_OPS         = NUM_TESTS * (5 + OPS_PER_TEST * 5);
	localparam int WATCHDOG_CYCLES = NUM_OPS * 6 + 100;

	logic                              clk_sys;
	logic                              reset;
	logic [zx_bus_pkg::MODE_W-1:0]     memory_mode;
	logic [zx_bus_pkg::CPU_ADDR_W-1:0] cpu_addr;
	logic [zx_bus_pkg::CPU_DATA_W-1:0] cpu_dout;
	logic                              iorq_n;
	logic                              mreq_n;
	logic                              rd_n;
	logic                              wr_n;
	logic                              m1_n;
	logic [zx_mem_pkg::RAM_ADDR_W-1:0] ram_addr;
	logic                              ram_rd;
	logic                              ram_we;
	logic [zx_mem_pkg::ROM_PAGE_W-1:0] rom_page;
	logic                              screen_page;
	logic [zx_mem_pkg::BANK_W-1:0]     ram_ext_bank;

	int                            seed;
	logic [zx_bus_pkg::MODE_W-1:0] modes [5];

	`include "paging_model.svh"

	zx_paging u_dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.memory_mode  (memory_mode),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.iorq_n       (iorq_n),
		.mreq_n       (mreq_n),
		.rd_n         (rd_n),
		.wr_n         (wr_n),
		.m1_n         (m1_n),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.rom_page     (rom_page),
		.screen_page  (screen_page),
		.ram_ext_bank (ram_ext_bank)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Simulation failed");
		$fatal(1, "The simulation hung and the watchdog ran out after %0d cycles",
			WATCHDOG_CYCLES);
	end

	// ====================
	// Compare tasks
	// ====================

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	task automatic abort_run(input string why);
		$display("Simulation failed");
		$fatal(1, "%s", why);
	endtask

	task automatic check_ram_addr(input logic [zx_mem_pkg::RAM_ADDR_W-1:0] got,
		input logic [zx_mem_pkg::RAM_ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: ram_addr %h for cpu_addr %h, expected %h",
				$time, got, cpu_addr, exp);
			abort_run("ram_addr mismatch");
		end
	endtask

	task automatic check_rom_page(input logic [zx_mem_pkg::ROM_PAGE_W-1:0] got,
		input logic [zx_mem_pkg::ROM_PAGE_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: rom_page %h, expected %h", $time, got, exp);
			abort_run("rom_page mismatch");
		end
	endtask

	task automatic check_enables(input logic got_rd, input logic got_we,
		input logic exp_rd, input logic exp_we);
		if (got_rd !== exp_rd || got_we !== exp_we) begin
			$display("error at %0d ns: ram_rd %b ram_we %b at cpu_addr %h, expected %b %b",
				$time, got_rd, got_we, cpu_addr, exp_rd, exp_we);
			abort_run("enable mismatch");
		end
	endtask

	task automatic check_ext_bank(input logic [zx_mem_pkg::BANK_W-1:0] got,
		input logic [zx_mem_pkg::BANK_W-1:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: ram_ext_bank %h, expected %h", $time, got, exp);
			abort_run("ram_ext_bank mismatch");
		end
	endtask

	task automatic check_screen(input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at %0d ns: screen_page %b, expected %b", $time, got, exp);
			abort_run("screen_page mismatch");
		end
	endtask

	// ====================
	// Bus tasks
	// ====================

	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DLY;
	endtask

	task automatic apply_reset(input logic [zx_bus_pkg::MODE_W-1:0] mode);
		memory_mode = mode;
		reset       = 1'b1;
		iorq_n      = 1'b1;
		mreq_n      = 1'b1;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
		// Selector only counts while reset is high
		memory_mode = (mode == zx_bus_pkg::MODE_ZX48) ? zx_bus_pkg::MODE_STD128
			: zx_bus_pkg::MODE_ZX48;
		model_reset(mode);
	endtask

	// Outputs are combinational and get sampled at the falling edge
	task automatic mem_access(input logic [15:0] a, input logic bus_mreq_n,
		input logic bus_rd_n, input logic bus_wr_n);
		cpu_addr = a;
		mreq_n   = bus_mreq_n;
		rd_n     = bus_rd_n;
		wr_n     = bus_wr_n;
		@(negedge clk_sys);
		check_ram_addr(ram_addr, model_ram_addr(a));
		check_rom_page(rom_page, model_rom_page());
		check_enables(ram_rd, ram_we, !bus_mreq_n && !bus_rd_n,
			!bus_mreq_n && !bus_wr_n && (a[15:14] != 2'b00 || model_special()));
		check_ext_bank(ram_ext_bank, model_ext_bank());
		check_screen(screen_page, m_7ffd[3]);
		next_cycle();
	endtask

	task automatic sweep_slots();
		logic [31:0] r;
		for (int s = 0; s < 4; s++) begin
			r = rand_word();
			mem_access({s[1:0], r[13:0]}, 1'b0, r[14], r[15]);
		end
	endtask

	// Level held one or two cycles, then the four-cycle gap
	task automatic io_write(input logic [15:0] a, input logic [7:0] d, input logic inta,
		input int hold);
		cpu_addr = a;
		cpu_dout = d;
		mreq_n   = 1'b1;
		rd_n     = 1'b1;
		iorq_n   = 1'b0;
		wr_n     = 1'b0;
		m1_n     = ~inta;
		repeat (hold) begin
			next_cycle();
			cpu_dout = ~d;   // Only the value at the first edge counts
		end
		iorq_n = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
		repeat (4) next_cycle();
		if (!inta)
			model_io_write(a, d);
	endtask

	task automatic random_op();
		logic [31:0] r;
		logic [31:0] w;
		logic [15:0] port;
		logic [7:0]  data;
		r = rand_word();
		if (r[2:0] < 3'd2) begin
			w = rand_word();
			case (w[1:0])
				2'd0:    port = 16'h7FFD;
				2'd1:    port = 16'h1FFD;
				2'd2:    port = zx_bus_pkg::PORT_DFFD;
				default: port = 16'hEFF7;
			endcase
			if (w[3:2] == 2'd0)
				port = r[31:16];   // Any address exercises the partial decode
			data = w[23:16];
			if (w[5:4] != 2'd0)
				data[5] = 1'b0;    // Keep the lock rare
			io_write(port, data, w[8:6] == 3'd0, w[9] ? 2 : 1);
			sweep_slots();
		end else begin
			mem_access(r[31:16], r[3] & r[4], r[5], r[6]);
		end
	endtask

	// ====================
	// Test sequence
	// ====================

	initial begin
		seed        = 32'h3067;
		reset       = 1'b1;
		memory_mode = zx_bus_pkg::MODE_STD128;
		cpu_addr    = 16'h0000;
		cpu_dout    = 8'h00;
		iorq_n      = 1'b1;
		mreq_n      = 1'b1;
		rd_n        = 1'b1;
		wr_n        = 1'b1;
		m1_n        = 1'b1;
		modes[0]    = zx_bus_pkg::MODE_STD128;
		modes[1]    = zx_bus_pkg::MODE_P1024;
		modes[2]    = zx_bus_pkg::MODE_PF1024;
		modes[3]    = zx_bus_pkg::MODE_ZX48;
		modes[4]    = zx_bus_pkg::MODE_PLUS3;

		for (int p = 0; p < NUM_PASSES; p++) begin
			for (int m = 0; m < 5; m++) begin
				apply_reset(modes[m]);
				sweep_slots();   // Reset mapping
				repeat (OPS_PER_TEST) random_op();
			end
		end

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- zx_paging.f
+incdir+verif
common/zx_bus_pkg.sv
common/zx_mem_pkg.sv
design/paging/port_decode.sv
design/paging/page_regs.sv
design/paging/addr_map.sv
design/zx_paging.sv
verif/tb_zx_paging.sv
